// File: hdl/pet_display_pkg.sv
package pet_display_pkg;

    // ******************************
    // pet states and animation tables
    // ******************************

    // values 5 to 7 are not valid states and map to frame 0
    typedef enum logic [2:0] {
        PET_IDLE     = 3'd0,
        PET_SLEEPING = 3'd1,
        PET_EATING   = 3'd2,
        PET_TEACHING = 3'd3,
        PET_DEAD     = 3'd4
    } pet_state_t;

    localparam int NUM_STATES    = 5;
    localparam int FRAME_BYTES   = 1024;
    localparam int BYTES_PER_ROW = 8;
    localparam int NUM_FRAMES    = 30;

    // frames per state, and where each state starts in the sprite memory
    localparam int FRAME_COUNT [NUM_STATES] = '{6, 4, 5, 7, 8};
    localparam int FRAME_BASE  [NUM_STATES] = '{0, 6, 10, 15, 22};

    typedef logic [9:0] byte_index_t;
    typedef logic [4:0] frame_num_t;
    typedef logic [2:0] anim_index_t;
    typedef logic [6:0] meter_level_t;

    // ******************************
    // meter bar layout
    // ******************************

    typedef struct packed {
        meter_level_t happiness;
        meter_level_t hunger;
        meter_level_t sleep;
    } meters_t;

    // first row of the happiness, hunger and sleep bars
    localparam int METER_ROW_BASE [3] = '{8, 18, 28};
    localparam int METER_ROWS = 5;

    localparam logic [7:0] SEG_FULL = 8'hEE;
    localparam logic [7:0] SEG_HALF = 8'hE0;

    // ******************************
    // transfer records
    // ******************************

    typedef struct packed {
        byte_index_t index;
        pet_state_t  state;
    } byte_req_t;

    typedef struct packed {
        logic        valid;
        byte_index_t index;
        pet_state_t  state;
        frame_num_t  frame;
    } lookup_t;

    typedef struct packed {
        logic [7:0] data;
        frame_num_t frame;
    } byte_resp_t;

    typedef struct packed {
        logic        valid;
        frame_num_t  frame;
        byte_index_t index;
        logic [7:0]  data;
    } sprite_load_t;

endpackage

// File: hdl/pet_request_port.sv
`timescale 1ns/10ps

module pet_request_port (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_req,
    input  pet_display_pkg::byte_req_t   i_req_data,
    output logic                         o_ack,
    input  pet_display_pkg::frame_num_t  i_frame,
    output pet_display_pkg::lookup_t     o_lookup,
    input  logic                         i_resp_valid
);

    typedef enum logic [1:0] {
        WAIT_REQ,
        BUSY,
        ACKED,
        WAIT_DROP
    } port_state_t;

    port_state_t                 state;
    logic                        lookup_valid;
    pet_display_pkg::byte_req_t  req_q;
    pet_display_pkg::frame_num_t frame_q;

    // one lookup per handshake, issued from the idle state only
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state        <= WAIT_REQ;
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= 1'b0;
            case (state)
                WAIT_REQ: begin
                    if (i_req) begin
                        lookup_valid <= 1'b1;
                        state        <= BUSY;
                    end
                end
                BUSY: begin
                    if (i_resp_valid) state <= ACKED;
                end
                ACKED: begin
                    if (!i_req) state <= WAIT_DROP;
                end
                default: state <= WAIT_REQ;
            endcase
        end
    end

    // the frame is taken from the sequencer at the same edge as the request
    always_ff @(posedge clk) begin
        if (state == WAIT_REQ && i_req) begin
            req_q   <= i_req_data;
            frame_q <= i_frame;
        end
    end

    // ack stays up through WAIT_DROP so it falls one cycle after i_req is seen low
    assign o_ack = (state == ACKED) || (state == WAIT_DROP);

    assign o_lookup = '{valid: lookup_valid, index: req_q.index, state: req_q.state,
                        frame: frame_q};

    a_ack_needs_req: assert property (@(posedge clk) disable iff (i_reset)
        $rose(o_ack) |-> i_req);

    a_no_lookup_while_acked: assert property (@(posedge clk) disable iff (i_reset)
        o_lookup.valid |-> !o_ack);

endmodule

// File: hdl/animation_sequencer.sv
`timescale 1ns/10ps

module animation_sequencer #(
    parameter int FRAME_TICKS = 2**23
) (
    input  logic                         clk,
    input  logic                         i_reset,
    input  pet_display_pkg::pet_state_t  i_state,
    output pet_display_pkg::frame_num_t  o_frame
);

    localparam int TIMER_W = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;

    logic [TIMER_W-1:0]           timer;
    logic                         timer_wrap;
    pet_display_pkg::anim_index_t anim_idx [pet_display_pkg::NUM_STATES];

    assign timer_wrap = (timer == TIMER_W'(FRAME_TICKS - 1));

    // ******************************
    // frame timer and animation indices
    // ******************************

    always_ff @(posedge clk) begin
        if (i_reset) begin
            timer <= '0;
            for (int s = 0; s < pet_display_pkg::NUM_STATES; s++) begin
                anim_idx[s] <= '0;
            end
        end else begin
            timer <= timer_wrap ? '0 : timer + 1'b1;
            // all states step together, each wrapping at its own frame count
            if (timer_wrap) begin
                for (int s = 0; s < pet_display_pkg::NUM_STATES; s++) begin
                    if (int'(anim_idx[s]) == pet_display_pkg::FRAME_COUNT[s] - 1) begin
                        anim_idx[s] <= '0;
                    end else begin
                        anim_idx[s] <= anim_idx[s] + 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        o_frame = '0;
        if (i_state <= pet_display_pkg::PET_DEAD) begin
            o_frame = 5'(pet_display_pkg::FRAME_BASE[i_state]) + 5'(anim_idx[i_state]);
        end
    end

    for (genvar s = 0; s < pet_display_pkg::NUM_STATES; s++) begin : g_idx_check
        a_idx_in_range: assert property (@(posedge clk) disable iff (i_reset)
            int'(anim_idx[s]) < pet_display_pkg::FRAME_COUNT[s]);
    end

endmodule

// File: hdl/sprite_memory.sv
`timescale 1ns/10ps

module sprite_memory (
    input  logic                          clk,
    input  pet_display_pkg::sprite_load_t i_load,
    input  pet_display_pkg::lookup_t      i_lookup,
    output logic [7:0]                    o_data
);

    localparam int DEPTH  = pet_display_pkg::NUM_FRAMES * pet_display_pkg::FRAME_BYTES;
    localparam int ADDR_W = $clog2(DEPTH);

    logic [7:0]        mem [DEPTH];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // a frame occupies one 1 KiB page, so the address is frame then index
    assign wr_addr = ADDR_W'({i_load.frame, i_load.index});
    assign rd_addr = ADDR_W'({i_lookup.frame, i_lookup.index});

    // ******************************
    // load port
    // ******************************

    always_ff @(posedge clk) begin
        if (i_load.valid && int'(i_load.frame) < pet_display_pkg::NUM_FRAMES) begin
            mem[wr_addr] <= i_load.data;
        end
    end

    // ******************************
    // read port
    // ******************************

    // data is held between lookups
    always_ff @(posedge clk) begin
        if (i_lookup.valid) begin
            o_data <= mem[rd_addr];
        end
    end

endmodule

// File: hdl/meter_overlay.sv
`timescale 1ns/10ps

module meter_overlay (
    input  logic                          clk,
    input  logic                          i_reset,
    input  pet_display_pkg::lookup_t      i_lookup,
    input  pet_display_pkg::meters_t      i_meters,
    input  logic [7:0]                    i_data,
    output pet_display_pkg::byte_resp_t   o_resp,
    output logic                          o_resp_valid
);

    logic                          valid_q;
    pet_display_pkg::byte_index_t  index_q;
    pet_display_pkg::pet_state_t   state_q;
    pet_display_pkg::frame_num_t   frame_q;
    pet_display_pkg::meters_t      meters_q;
    pet_display_pkg::meter_level_t level [3];
    logic [6:0]                    row;
    logic [2:0]                    col;
    logic [7:0]                    byte_out;

    // stage aligned with the memory read
    always_ff @(posedge clk) begin
        if (i_reset) valid_q <= 1'b0;
        else         valid_q <= i_lookup.valid;
    end

    always_ff @(posedge clk) begin
        if (i_lookup.valid) begin
            index_q  <= i_lookup.index;
            state_q  <= i_lookup.state;
            frame_q  <= i_lookup.frame;
            meters_q <= i_meters;
        end
    end

    assign level[0] = meters_q.happiness;
    assign level[1] = meters_q.hunger;
    assign level[2] = meters_q.sleep;
    assign row      = index_q[9:3];
    assign col      = index_q[2:0];

    // ******************************
    // meter bar decode
    // ******************************

    // columns 1 to 5 are segments, each worth 20 points with a half step at 10
    always_comb begin
        byte_out = i_data;
        if (state_q > pet_display_pkg::PET_DEAD) byte_out = '0;
        for (int m = 0; m < 3; m++) begin
            if (int'(row) >= pet_display_pkg::METER_ROW_BASE[m] &&
                int'(row) < pet_display_pkg::METER_ROW_BASE[m] + pet_display_pkg::METER_ROWS &&
                col >= 3'd1 && col <= 3'd5) begin
                if (int'(level[m]) > 110 - 20 * int'(col)) begin
                    byte_out = pet_display_pkg::SEG_FULL;
                end else if (int'(level[m]) > 100 - 20 * int'(col)) begin
                    byte_out = pet_display_pkg::SEG_HALF;
                end else begin
                    byte_out = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_resp       <= '0;
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= valid_q;
            if (valid_q) o_resp <= '{data: byte_out, frame: frame_q};
        end
    end

    a_single_resp: assert property (@(posedge clk) disable iff (i_reset)
        o_resp_valid |=> !o_resp_valid);

endmodule

// File: hdl/pet_display.sv
`timescale 1ns/10ps

module pet_display #(
    parameter int FRAME_TICKS = 2**23
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_req,
    input  pet_display_pkg::byte_req_t    i_req_data,
    output logic                          o_ack,
    output pet_display_pkg::byte_resp_t   o_resp,
    input  pet_display_pkg::sprite_load_t i_load,
    input  pet_display_pkg::meters_t      i_meters
);

    pet_display_pkg::frame_num_t frame;
    pet_display_pkg::lookup_t    lookup;
    logic [7:0]                  mem_data;
    logic                        resp_valid;

    pet_request_port u_request_port (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_req        (i_req),
        .i_req_data   (i_req_data),
        .o_ack        (o_ack),
        .i_frame      (frame),
        .o_lookup     (lookup),
        .i_resp_valid (resp_valid)
    );

    // the sequencer sees the live request state so the frame is ready at capture
    animation_sequencer #(
        .FRAME_TICKS (FRAME_TICKS)
    ) u_sequencer (
        .clk     (clk),
        .i_reset (i_reset),
        .i_state (i_req_data.state),
        .o_frame (frame)
    );

    sprite_memory u_sprite_memory (
        .clk      (clk),
        .i_load   (i_load),
        .i_lookup (lookup),
        .o_data   (mem_data)
    );

    meter_overlay u_meter_overlay (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_lookup     (lookup),
        .i_meters     (i_meters),
        .i_data       (mem_data),
        .o_resp       (o_resp),
        .o_resp_valid (resp_valid)
    );

endmodule

// File: sim/pet_display_checker.sv
`timescale 1ns/10ps

module pet_display_checker #(
    parameter int FRAME_TICKS = 64,
    parameter int MEM_BYTES   = 30720
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_req,
    input  pet_display_pkg::byte_req_t  i_req_data,
    input  logic                        i_ack,
    input  pet_display_pkg::byte_resp_t i_resp,
    input  pet_display_pkg::meters_t    i_meters,
    input  logic [7:0]                  i_ref_mem [MEM_BYTES],
    input  logic                        i_report,
    output int                          o_errors
);

    // o_ack changes this many cycles after the request edge and is sampled one edge later
    localparam int ACK_RISE_CYCLES = 3;
    localparam int ACK_FALL_CYCLES = 1;
    localparam int NS = pet_display_pkg::NUM_STATES;

    int                          cycle = 0;
    int                          checks = 0;
    int                          hs_errors = 0;
    int                          frame_errors = 0;
    int                          data_errors = 0;
    int                          step_errors = 0;
    logic                        reset_q = 1'b0;
    logic                        req_q = 1'b0;
    logic                        ack_q = 1'b0;
    logic                        pending = 1'b0;
    logic                        dropping = 1'b0;
    int                          req_cycle;
    int                          drop_cycle;
    pet_display_pkg::byte_req_t  req;
    pet_display_pkg::meters_t    meters;
    pet_display_pkg::frame_num_t last_frame [NS];
    int                          last_cycle [NS];
    bit                          seen [NS];
    int                          steps [NS];

    assign o_errors = hs_errors + frame_errors + data_errors + step_errors;

    // image byte at the returned frame, unless a meter bar covers the position
    function automatic logic [7:0] expected_byte(
        input pet_display_pkg::frame_num_t  frame,
        input pet_display_pkg::byte_index_t index,
        input int                           state,
        input pet_display_pkg::meters_t     levels
    );
        int         row;
        int         col;
        int         lvl;
        int         m;
        logic [7:0] result;
        row = int'(index) / pet_display_pkg::BYTES_PER_ROW;
        col = int'(index) % pet_display_pkg::BYTES_PER_ROW;
        result = 8'h00;
        if (state < NS && int'(frame) < pet_display_pkg::NUM_FRAMES) begin
            result = i_ref_mem[int'(frame) * pet_display_pkg::FRAME_BYTES + int'(index)];
        end
        for (m = 0; m < 3; m++) begin
            lvl = (m == 0) ? int'(levels.happiness) :
                  (m == 1) ? int'(levels.hunger) : int'(levels.sleep);
            if (row >= pet_display_pkg::METER_ROW_BASE[m] && col >= 1 && col <= 5 &&
                row < pet_display_pkg::METER_ROW_BASE[m] + pet_display_pkg::METER_ROWS) begin
                // segment k is full above 110-20k and half full above 100-20k
                if (lvl > 110 - 20 * col) begin
                    result = pet_display_pkg::SEG_FULL;
                end else if (lvl > 100 - 20 * col) begin
                    result = pet_display_pkg::SEG_HALF;
                end else begin
                    result = 8'h00;
                end
            end
        end
        return result;
    endfunction

    task automatic check_response();
        int         s;
        int         lo;
        int         next_frame;
        logic [7:0] exp_data;
        s = int'(req.state);
        checks++;
        if (s < NS) begin
            lo = pet_display_pkg::FRAME_BASE[s];
            if (int'(i_resp.frame) < lo ||
                int'(i_resp.frame) > lo + pet_display_pkg::FRAME_COUNT[s] - 1) begin
                frame_errors++;
                $display("CHECK FAILED o_resp.frame: got %02h, expected %02h to %02h", i_resp.frame,
                         lo, lo + pet_display_pkg::FRAME_COUNT[s] - 1);
            end
            // less than one timer period apart, so at most one step in between
            if (seen[s] && req_cycle - last_cycle[s] < FRAME_TICKS &&
                i_resp.frame != last_frame[s]) begin
                next_frame = lo + (int'(last_frame[s]) - lo + 1) % pet_display_pkg::FRAME_COUNT[s];
                if (int'(i_resp.frame) != next_frame) begin
                    frame_errors++;
                    $display("CHECK FAILED o_resp.frame: got %02h, expected %02h or %02h",
                             i_resp.frame, last_frame[s], next_frame);
                end else begin
                    steps[s]++;
                end
            end
            seen[s]       = 1'b1;
            last_frame[s] = i_resp.frame;
            last_cycle[s] = req_cycle;
        end else if (i_resp.frame !== '0) begin
            frame_errors++;
            $display("CHECK FAILED o_resp.frame: got %02h, expected 00", i_resp.frame);
        end
        exp_data = expected_byte(i_resp.frame, req.index, s, meters);
        if (i_resp.data !== exp_data) begin
            data_errors++;
            $display("CHECK FAILED o_resp.data: got %02h, expected %02h (state %0d, index %03h)",
                     i_resp.data, exp_data, s, req.index);
        end
    endtask

    // ******************************
    // handshake monitor
    // ******************************

    always @(posedge clk) begin
        cycle++;
        if (reset_q && i_ack !== 1'b0) begin
            hs_errors++;
            $display("CHECK FAILED o_ack: got %h, expected 0 after reset", i_ack);
        end
        if (i_reset) begin
            pending  = 1'b0;
            dropping = 1'b0;
            seen     = '{default: 1'b0};
        end else begin
            if (i_req && !req_q && !i_ack) begin
                pending   = 1'b1;
                req_cycle = cycle;
                req       = i_req_data;
                meters    = i_meters;
            end
            if (i_ack && !ack_q) begin
                if (!pending) begin
                    hs_errors++;
                    $display("o_ack rose with no request open");
                end else begin
                    if (cycle - req_cycle - 1 != ACK_RISE_CYCLES) begin
                        hs_errors++;
                        $display("o_ack rose %0d cycles after the request, expected %0d",
                                 cycle - req_cycle - 1, ACK_RISE_CYCLES);
                    end
                    check_response();
                    pending = 1'b0;
                end
            end
            if (i_ack && req_q && !i_req) begin
                dropping   = 1'b1;
                drop_cycle = cycle;
            end
            if (ack_q && !i_ack) begin
                if (!dropping) begin
                    hs_errors++;
                    $display("o_ack fell while i_req was still high");
                end else if (cycle - drop_cycle - 1 != ACK_FALL_CYCLES) begin
                    hs_errors++;
                    $display("o_ack fell %0d cycles after i_req dropped, expected %0d",
                             cycle - drop_cycle - 1, ACK_FALL_CYCLES);
                end
                dropping = 1'b0;
            end
        end
        reset_q = i_reset;
        req_q   = i_req;
        ack_q   = i_ack;
    end

    // every state should have gone through a whole animation cycle by now
    always @(posedge i_report) begin
        for (int s = 0; s < NS; s++) begin
            if (steps[s] < pet_display_pkg::FRAME_COUNT[s]) begin
                step_errors++;
                $display("state %0d stepped only %0d times, too few for a full cycle", s, steps[s]);
            end
        end
        $display("checks %0d, handshake errors %0d, frame errors %0d, data errors %0d, step errors %0d",
                 checks, hs_errors, frame_errors, data_errors, step_errors);
    end

endmodule

// File: sim/tb_pet_display.sv
`timescale 1ns/10ps

module tb_pet_display;

    localparam int FRAME_TICKS = 64;
    localparam int MEM_BYTES   = pet_display_pkg::NUM_FRAMES * pet_display_pkg::FRAME_BYTES;
    localparam int WAIT_LIMIT  = 50;
    localparam int RANDOM_REQS = 300;
    localparam int STEP_REQS   = 100;

    logic                          clk;
    logic                          i_reset;
    logic                          i_req;
    pet_display_pkg::byte_req_t    i_req_data;
    logic                          o_ack;
    pet_display_pkg::byte_resp_t   o_resp;
    pet_display_pkg::sprite_load_t i_load;
    pet_display_pkg::meters_t      i_meters;

    logic [7:0]  ref_mem [MEM_BYTES];
    logic [31:0] lfsr;
    logic        timed_out;
    logic        report;
    int          error_count;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    pet_display #(.FRAME_TICKS(FRAME_TICKS)) dut (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_req      (i_req),
        .i_req_data (i_req_data),
        .o_ack      (o_ack),
        .o_resp     (o_resp),
        .i_load     (i_load),
        .i_meters   (i_meters)
    );

    pet_display_checker #(.FRAME_TICKS(FRAME_TICKS), .MEM_BYTES(MEM_BYTES)) u_checker (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_req      (i_req),
        .i_req_data (i_req_data),
        .i_ack      (o_ack),
        .i_resp     (o_resp),
        .i_meters   (i_meters),
        .i_ref_mem  (ref_mem),
        .i_report   (report),
        .o_errors   (error_count)
    );

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step for each bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic pet_display_pkg::meters_t random_meters();
        pet_display_pkg::meters_t m;
        m.happiness = 7'(take_bits(7) % 101);
        m.hunger    = 7'(take_bits(7) % 101);
        m.sleep     = 7'(take_bits(7) % 101);
        return m;
    endfunction

    // writes every byte of every frame and keeps a copy for the checker
    task automatic load_sprites();
        logic [7:0] data;
        for (int f = 0; f < pet_display_pkg::NUM_FRAMES; f++) begin
            for (int i = 0; i < pet_display_pkg::FRAME_BYTES; i++) begin
                data = 8'(take_bits(8));
                @(posedge clk);
                i_load <= '{valid: 1'b1, frame: 5'(f), index: 10'(i), data: data};
                ref_mem[f * pet_display_pkg::FRAME_BYTES + i] = data;
            end
        end
        @(posedge clk);
        i_load <= '0;
    endtask

    // one full four-phase handshake, with the request held a few extra cycles at random
    task automatic request_byte(input pet_display_pkg::byte_req_t r,
                                input pet_display_pkg::meters_t m);
        int waited;
        int hold;
        if (timed_out) return;
        hold = int'(take_bits(2));
        @(posedge clk);
        i_req_data <= r;
        i_meters   <= m;
        i_req      <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!o_ack && waited < WAIT_LIMIT);
        if (!o_ack) begin
            $display("timeout, o_ack never rose for request at index %03h", r.index);
            timed_out = 1'b1;
        end else begin
            repeat (hold) @(posedge clk);
            i_req <= 1'b0;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (o_ack && waited < WAIT_LIMIT);
            if (o_ack) begin
                $display("timeout, o_ack stayed high after i_req was lowered");
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin : stimulus
        pet_display_pkg::byte_req_t req;
        pet_display_pkg::meters_t   meters;
        lfsr       = 32'hbb5b_91a7;
        timed_out  = 1'b0;
        report     = 1'b0;
        i_reset    = 1'b1;
        i_req      = 1'b0;
        i_req_data = '0;
        i_load     = '0;
        i_meters   = '0;
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        load_sprites();

        // random requests, invalid states included
        for (int n = 0; n < RANDOM_REQS; n++) begin
            req.index = 10'(take_bits(10));
            req.state = pet_display_pkg::pet_state_t'(3'(take_bits(3)));
            request_byte(req, random_meters());
        end

        // ******************************
        // meter levels 0, 100 and both sides of every threshold
        // ******************************
        for (int lv = 0; lv <= 100; lv++) begin
            if (lv % 10 <= 1) begin
                meters = '{happiness: 7'(lv), hunger: 7'(lv), sleep: 7'(lv)};
                for (int m = 0; m < 3; m++) begin
                    for (int col = 1; col <= 5; col++) begin
                        req.index = 10'((pet_display_pkg::METER_ROW_BASE[m] +
                                         int'(take_bits(3)) % 5) * 8 + col);
                        req.state = pet_display_pkg::pet_state_t'(3'(take_bits(3)));
                        request_byte(req, meters);
                    end
                end
            end
        end

        // back-to-back requests for one state span many timer periods
        for (int s = 0; s < pet_display_pkg::NUM_STATES; s++) begin
            for (int n = 0; n < STEP_REQS; n++) begin
                req.index = 10'(take_bits(10));
                req.state = pet_display_pkg::pet_state_t'(3'(s));
                request_byte(req, random_meters());
            end
        end

        @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        if (!timed_out && error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: pet_display.f
hdl/pet_display_pkg.sv
hdl/pet_request_port.sv
hdl/animation_sequencer.sv
hdl/sprite_memory.sv
hdl/meter_overlay.sv
hdl/pet_display.sv
sim/pet_display_checker.sv
sim/tb_pet_display.sv

// File: Makefile
# Verilator build and run of the pet display testbench

VERILATOR ?= verilator
TOP       ?= tb_pet_display
FILELIST  ?= pet_display.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the simulation and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
